//--- Bender.yml
package:
  name: rv32i_core

sources:
  - core_pkg.sv
  - reg_file.sv
  - inst_decode.sv
  - load_store_unit.sv
  - exec_unit.sv
  - core_top.sv
  - target: test
    files:
      - core_properties.sv
      - tb_core.sv

//--- core_pkg.sv
package core_pkg;

  // data, address and pc width
  typedef logic [31:0] word_t;

  // register index
  typedef logic [4:0] reg_addr_t;

  // one enable bit per byte lane
  typedef logic [3:0] byte_mask_t;

  localparam word_t RESET_PC = 32'h8000_0000;

  // major opcodes of the supported subset
  typedef enum logic [6:0] {
    OP_LOAD  = 7'b000_0011,
    OP_IMM   = 7'b001_0011,
    OP_AUIPC = 7'b001_0111,
    OP_STORE = 7'b010_0011,
    OP_LUI   = 7'b011_0111,
    OP_JALR  = 7'b110_0111,
    OP_JAL   = 7'b110_1111
  } opcode_e;

  // funct3 of loads, stores use the first three
  typedef enum logic [2:0] {
    MEM_B  = 3'b000,
    MEM_H  = 3'b001,
    MEM_W  = 3'b010,
    MEM_BU = 3'b100,
    MEM_HU = 3'b101
  } mem_size_e;

  // register write-back source
  typedef enum logic [1:0] {
    WB_ALU,
    WB_LINK,
    WB_LOAD
  } wb_sel_e;

  // first adder operand
  typedef enum logic [1:0] {
    OPA_RS1,
    OPA_PC,
    OPA_ZERO
  } op_a_sel_e;

  // immediate formats
  typedef enum logic [2:0] {
    IMM_NONE,
    IMM_I,
    IMM_S,
    IMM_U,
    IMM_J
  } imm_kind_e;

endpackage

//--- core_properties.sv
`timescale 1ns/10ps

module core_properties #(
  parameter core_pkg::word_t reset_pc = core_pkg::RESET_PC
) (
  input logic                 clk,
  input logic                 rst,
  input core_pkg::word_t      pc,
  input logic                 dmem_ren,
  input logic                 dmem_wen,
  input core_pkg::byte_mask_t dmem_wmask
);

  int fail_count = 0;

  assert property (@(posedge clk) !(dmem_ren && dmem_wen)) else begin
    fail_count++;
    $error("load and store strobes high together");
  end

  // no stray byte enables outside a store
  assert property (@(posedge clk) !dmem_wen |-> (dmem_wmask == 4'b0000)) else begin
    fail_count++;
    $error("byte mask set while no store is active");
  end

  assert property (@(posedge clk) disable iff (rst) pc[1:0] == 2'b00) else begin
    fail_count++;
    $error("pc lost word alignment");
  end

  assert property (@(posedge clk) rst |=> (pc == reset_pc)) else begin
    fail_count++;
    $error("pc differs from the reset value after reset");
  end

endmodule

bind exec_unit core_properties #(.reset_pc(reset_pc)) core_properties_inst (.*);

//--- core_top.sv
`timescale 1ns/10ps

module core_top #(
  parameter core_pkg::word_t reset_pc = core_pkg::RESET_PC
) (
  input  logic                 clk,
  input  logic                 rst,
  input  core_pkg::word_t      inst,
  output core_pkg::word_t      pc,
  output core_pkg::word_t      dmem_addr,
  output core_pkg::word_t      dmem_wdata,
  output logic                 dmem_ren,
  output logic                 dmem_wen,
  output core_pkg::byte_mask_t dmem_wmask,
  input  core_pkg::word_t      dmem_rdata
);

  import core_pkg::*;

  reg_addr_t rs1_addr;
  reg_addr_t rs2_addr;
  reg_addr_t rd_addr;
  word_t     imm;
  op_a_sel_e op_a_sel;
  wb_sel_e   wb_sel;
  logic      reg_wen;
  logic      mem_ren;
  logic      mem_wen;
  mem_size_e mem_size;
  word_t     rs1_data;
  word_t     rs2_data;
  logic      rf_wen;
  reg_addr_t rf_waddr;
  word_t     rf_wdata;

  inst_decode inst_decode_inst (
    .inst    (inst),
    .rs1_addr(rs1_addr),
    .rs2_addr(rs2_addr),
    .rd_addr (rd_addr),
    .imm     (imm),
    .op_a_sel(op_a_sel),
    .wb_sel  (wb_sel),
    .reg_wen (reg_wen),
    .mem_ren (mem_ren),
    .mem_wen (mem_wen),
    .mem_size(mem_size)
  );

  reg_file reg_file_inst (
    .clk     (clk),
    .wen     (rf_wen),
    .waddr   (rf_waddr),
    .wdata   (rf_wdata),
    .rs1_addr(rs1_addr),
    .rs2_addr(rs2_addr),
    .rs1_data(rs1_data),
    .rs2_data(rs2_data)
  );

  exec_unit #(
    .reset_pc(reset_pc)
  ) exec_unit_inst (
    .clk       (clk),
    .rst       (rst),
    .imm       (imm),
    .rs1_data  (rs1_data),
    .rs2_data  (rs2_data),
    .op_a_sel  (op_a_sel),
    .wb_sel    (wb_sel),
    .reg_wen   (reg_wen),
    .mem_ren   (mem_ren),
    .mem_wen   (mem_wen),
    .mem_size  (mem_size),
    .rd_addr   (rd_addr),
    .pc        (pc),
    .rf_wen    (rf_wen),
    .rf_waddr  (rf_waddr),
    .rf_wdata  (rf_wdata),
    .dmem_addr (dmem_addr),
    .dmem_wdata(dmem_wdata),
    .dmem_ren  (dmem_ren),
    .dmem_wen  (dmem_wen),
    .dmem_wmask(dmem_wmask),
    .dmem_rdata(dmem_rdata)
  );

endmodule

//--- exec_unit.sv
`timescale 1ns/10ps

module exec_unit #(
  parameter core_pkg::word_t reset_pc = core_pkg::RESET_PC
) (
  input  logic                 clk,
  input  logic                 rst,
  input  core_pkg::word_t      imm,
  input  core_pkg::word_t      rs1_data,
  input  core_pkg::word_t      rs2_data,
  input  core_pkg::op_a_sel_e  op_a_sel,
  input  core_pkg::wb_sel_e    wb_sel,
  input  logic                 reg_wen,
  input  logic                 mem_ren,
  input  logic                 mem_wen,
  input  core_pkg::mem_size_e  mem_size,
  input  core_pkg::reg_addr_t  rd_addr,
  output core_pkg::word_t      pc,
  output logic                 rf_wen,
  output core_pkg::reg_addr_t  rf_waddr,
  output core_pkg::word_t      rf_wdata,
  output core_pkg::word_t      dmem_addr,
  output core_pkg::word_t      dmem_wdata,
  output logic                 dmem_ren,
  output logic                 dmem_wen,
  output core_pkg::byte_mask_t dmem_wmask,
  input  core_pkg::word_t      dmem_rdata
);

  import core_pkg::*;

  word_t      op_a;
  word_t      sum;
  word_t      static_pc;
  word_t      next_pc;
  word_t      load_result;
  byte_mask_t lane_mask;

  always_comb begin
    case (op_a_sel)
      OPA_PC:   op_a = pc;
      OPA_ZERO: op_a = '0;
      default:  op_a = rs1_data;
    endcase
  end

  // one adder for addresses, targets and addi/lui/auipc
  assign sum       = op_a + imm;
  assign static_pc = pc + 32'd4;

  // jumps are the only link writers, bit 0 cleared for jalr
  assign next_pc = (wb_sel == WB_LINK) ? {sum[31:1], 1'b0} : static_pc;

  always_ff @(posedge clk) begin
    if (rst) begin
      pc <= reset_pc;
    end else begin
      pc <= next_pc;
    end
  end

  load_store_unit lsu_inst (
    .addr_low   (sum[1:0]),
    .mem_size   (mem_size),
    .store_data (rs2_data),
    .load_word  (dmem_rdata),
    .wmask      (lane_mask),
    .lane_wdata (dmem_wdata),
    .load_result(load_result)
  );

  assign dmem_addr  = sum;
  assign dmem_ren   = mem_ren;
  assign dmem_wen   = mem_wen;
  assign dmem_wmask = mem_wen ? lane_mask : '0;

  // write-back
  assign rf_wen   = reg_wen;
  assign rf_waddr = rd_addr;
  always_comb begin
    case (wb_sel)
      WB_LINK: rf_wdata = static_pc;
      WB_LOAD: rf_wdata = load_result;
      default: rf_wdata = sum;
    endcase
  end

endmodule

//--- inst_decode.sv
`timescale 1ns/10ps

module inst_decode (
  input  core_pkg::word_t     inst,
  output core_pkg::reg_addr_t rs1_addr,
  output core_pkg::reg_addr_t rs2_addr,
  output core_pkg::reg_addr_t rd_addr,
  output core_pkg::word_t     imm,
  output core_pkg::op_a_sel_e op_a_sel,
  output core_pkg::wb_sel_e   wb_sel,
  output logic                reg_wen,
  output logic                mem_ren,
  output logic                mem_wen,
  output core_pkg::mem_size_e mem_size
);

  import core_pkg::*;

  opcode_e    opcode;
  logic [2:0] funct3;
  imm_kind_e  imm_kind;

  // fixed field positions
  assign opcode   = opcode_e'(inst[6:0]);
  assign rd_addr  = inst[11:7];
  assign funct3   = inst[14:12];
  assign rs1_addr = inst[19:15];
  assign rs2_addr = inst[24:20];

  // control levels per opcode
  always_comb begin
    imm_kind = IMM_NONE;
    op_a_sel = OPA_RS1;
    wb_sel   = WB_ALU;
    reg_wen  = 1'b0;
    mem_ren  = 1'b0;
    mem_wen  = 1'b0;
    mem_size = MEM_W;
    case (opcode)
      OP_IMM: begin
        imm_kind = IMM_I;
        // only addi of the op-imm group is implemented
        reg_wen  = (funct3 == 3'b000);
      end
      OP_LUI: begin
        imm_kind = IMM_U;
        op_a_sel = OPA_ZERO;
        reg_wen  = 1'b1;
      end
      OP_AUIPC: begin
        imm_kind = IMM_U;
        op_a_sel = OPA_PC;
        reg_wen  = 1'b1;
      end
      OP_JAL: begin
        imm_kind = IMM_J;
        op_a_sel = OPA_PC;
        wb_sel   = WB_LINK;
        reg_wen  = 1'b1;
      end
      OP_JALR: begin
        imm_kind = IMM_I;
        wb_sel   = WB_LINK;
        reg_wen  = 1'b1;
      end
      OP_LOAD: begin
        imm_kind = IMM_I;
        wb_sel   = WB_LOAD;
        reg_wen  = 1'b1;
        mem_ren  = 1'b1;
        mem_size = mem_size_e'(funct3);
      end
      OP_STORE: begin
        imm_kind = IMM_S;
        mem_wen  = 1'b1;
        mem_size = mem_size_e'(funct3);
      end
      default: begin
        // unknown opcode, behaves as a nop
        imm_kind = IMM_NONE;
      end
    endcase
  end

  // sign-extended immediates
  always_comb begin
    case (imm_kind)
      IMM_I:   imm = {{20{inst[31]}}, inst[31:20]};
      IMM_S:   imm = {{20{inst[31]}}, inst[31:25], inst[11:7]};
      IMM_U:   imm = {inst[31:12], 12'h000};
      IMM_J:   imm = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
      default: imm = '0;
    endcase
  end

endmodule

//--- load_store_unit.sv
`timescale 1ns/10ps

module load_store_unit (
  input  logic [1:0]           addr_low,
  input  core_pkg::mem_size_e  mem_size,
  input  core_pkg::word_t      store_data,
  input  core_pkg::word_t      load_word,
  output core_pkg::byte_mask_t wmask,
  output core_pkg::word_t      lane_wdata,
  output core_pkg::word_t      load_result
);

  import core_pkg::*;

  word_t      load_shifted;
  logic [4:0] lane_shift;

  // bit offset of the addressed byte lane
  assign lane_shift = {addr_low, 3'b000};

  // store side, mask and lane placement
  always_comb begin
    wmask      = '0;
    lane_wdata = store_data;
    case (mem_size)
      MEM_B: begin
        wmask      = byte_mask_t'(4'b0001 << addr_low);
        lane_wdata = word_t'({24'h000000, store_data[7:0]}) << lane_shift;
      end
      MEM_H: begin
        // halfword needs an even address
        if (!addr_low[0]) begin
          wmask      = addr_low[1] ? 4'b1100 : 4'b0011;
          lane_wdata = word_t'({16'h0000, store_data[15:0]}) << lane_shift;
        end
      end
      MEM_W: begin
        if (addr_low == 2'b00) begin
          wmask = 4'b1111;
        end
      end
      default: begin
        wmask = '0;
      end
    endcase
  end

  // move the addressed lane down to bit 0
  assign load_shifted = load_word >> lane_shift;

  // load side, extract then extend
  always_comb begin
    load_result = '0;
    case (mem_size)
      MEM_B: begin
        load_result = {{24{load_shifted[7]}}, load_shifted[7:0]};
      end
      MEM_BU: begin
        load_result = {24'h000000, load_shifted[7:0]};
      end
      MEM_H: begin
        if (!addr_low[0]) begin
          load_result = {{16{load_shifted[15]}}, load_shifted[15:0]};
        end
      end
      MEM_HU: begin
        if (!addr_low[0]) begin
          load_result = {16'h0000, load_shifted[15:0]};
        end
      end
      MEM_W: begin
        if (addr_low == 2'b00) begin
          load_result = load_word;
        end
      end
      default: begin
        load_result = '0;
      end
    endcase
  end

endmodule

//--- reg_file.sv
`timescale 1ns/10ps

module reg_file (
  input  logic               clk,
  input  logic               wen,
  input  core_pkg::reg_addr_t waddr,
  input  core_pkg::word_t    wdata,
  input  core_pkg::reg_addr_t rs1_addr,
  input  core_pkg::reg_addr_t rs2_addr,
  output core_pkg::word_t    rs1_data,
  output core_pkg::word_t    rs2_data
);

  import core_pkg::*;

  // x1..x31, x0 is not stored
  word_t regs [1:31];

  always_ff @(posedge clk) begin
    if (wen && (waddr != '0)) begin
      regs[waddr] <= wdata;
    end
  end

  // combinational reads, old value until the edge
  always_comb begin
    if (rs1_addr == '0) begin
      rs1_data = '0;
    end else begin
      rs1_data = regs[rs1_addr];
    end
  end

  always_comb begin
    if (rs2_addr == '0) begin
      rs2_data = '0;
    end else begin
      rs2_data = regs[rs2_addr];
    end
  end

endmodule

//--- tb.f
core_pkg.sv
reg_file.sv
inst_decode.sv
load_store_unit.sv
exec_unit.sv
core_top.sv
core_properties.sv
tb_core.sv

//--- tb_core.sv
`timescale 1ns/10ps

module tb_core;

  import core_pkg::*;

  localparam int NUM_INSTS = 400;
  // 10 reset cycles, 400 instructions, some headroom
  localparam int MAX_CYCLES = 500;
  localparam word_t DATA_BASE = 32'h0000_1000;

  logic       clk = 1'b0;
  logic       rst = 1'b1;
  word_t      inst = 32'h0000_0013;
  word_t      pc;
  word_t      dmem_addr;
  word_t      dmem_wdata;
  logic       dmem_ren;
  logic       dmem_wen;
  byte_mask_t dmem_wmask;
  word_t      dmem_rdata;

  // data memory, wraps every 1 KB above DATA_BASE
  word_t      mem [0:255];
  word_t      regs [0:31];
  word_t      model_pc;
  int         mismatches = 0;
  int         failures = 0;
  int         cycles = 0;
  // predicted effects of the instruction in flight
  logic       exp_wen;
  logic       exp_load;
  logic       exp_store;
  reg_addr_t  exp_rd;
  word_t      exp_wval;
  word_t      exp_addr;
  byte_mask_t exp_mask;
  word_t      exp_wdata;
  word_t      exp_next_pc;
  logic       store_next = 1'b0;
  reg_addr_t  last_rd;

  core_top #(.reset_pc(RESET_PC)) core_top_inst (.*);

  assign dmem_rdata = mem[dmem_addr[9:2]];

  always #50 clk = ~clk;

  always @(posedge clk) begin
    cycles++;
    if (cycles > MAX_CYCLES) begin
      failures++;
      $display("timeout: the program did not complete within %0d cycles", MAX_CYCLES);
      finish_run();
    end
  end

  task automatic report_mismatch(input string name, input int n, input word_t expected,
                                 input word_t actual);
    mismatches++;
    $display("mismatch: %s at instruction %0d, expected %h, actual %h",
             name, n, expected, actual);
  endtask

  task automatic finish_run();
    int asserts;
    asserts = core_top_inst.exec_unit_inst.core_properties_inst.fail_count;
    $display("errors: %0d mismatches, %0d other failures, %0d assertion failures",
             mismatches, failures, asserts);
    if (mismatches + failures + asserts == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  endtask

  // byte or half picked from the lane, then extended
  function automatic word_t load_value(word_t w, logic [1:0] lo, logic [2:0] f3);
    logic [7:0]  b;
    logic [15:0] h;
    b = w[8*lo +: 8];
    h = w[16*lo[1] +: 16];
    case (f3)
      3'b000:  return {{24{b[7]}}, b};
      3'b100:  return {24'h000000, b};
      3'b001:  return lo[0] ? 32'h0 : {{16{h[15]}}, h};
      3'b101:  return lo[0] ? 32'h0 : {16'h0000, h};
      3'b010:  return (lo == 2'b00) ? w : 32'h0;
      default: return 32'h0;
    endcase
  endfunction

  // setup for n < 9, random after that; encodes and predicts
  task automatic next_insn(input int n, output word_t ins);
    opcode_e    op;
    reg_addr_t  rd;
    reg_addr_t  rs1;
    reg_addr_t  rs2;
    logic [2:0] f3;
    logic [1:0] lo;
    word_t      imm;
    word_t      r;
    r   = $urandom;
    rd  = reg_addr_t'($urandom_range(0, 7));
    rs1 = reg_addr_t'($urandom_range(0, 7));
    rs2 = reg_addr_t'($urandom_range(0, 7));
    f3  = 3'b000;
    imm = {{20{r[11]}}, r[11:0]};
    if (n < 2) begin
      // x8 is the data base, x9 the jalr base
      op  = OP_LUI;
      rd  = reg_addr_t'(8 + n);
      imm = (n == 0) ? DATA_BASE : RESET_PC;
    end else if (n < 9) begin
      op  = OP_IMM;
      rd  = reg_addr_t'(n - 1);
      rs1 = '0;
    end else begin
      case (store_next ? 9 : $urandom_range(0, 9))
        0, 1:    op = OP_IMM;
        2:       op = OP_LUI;
        3:       op = OP_AUIPC;
        4:       op = OP_JAL;
        5:       op = OP_JALR;
        6, 7:    op = OP_LOAD;
        default: op = OP_STORE;
      endcase
      case (op)
        OP_LUI, OP_AUIPC: imm = {r[31:12], 12'h000};
        OP_JAL: imm = RESET_PC + 4 * $urandom_range(0, 1023) - model_pc;
        OP_JALR: begin
          rs1 = 5'd9;
          imm = 4 * $urandom_range(0, 511) + r[0];
        end
        OP_LOAD, OP_STORE: begin
          rs1 = 5'd8;
          f3  = 3'($urandom_range(0, (op == OP_LOAD) ? 4 : 2));
          if (f3 > 3'd2) f3 = f3 + 3'd1;
          if (store_next) begin
            f3  = 3'd2;
            rs2 = last_rd;
          end
          // about one access in four may be misaligned
          lo  = r[15:14] & ((r[13:12] == 2'b00) ? 2'b11 :
                            {f3[1:0] != 2'b10, f3[1:0] == 2'b00});
          lo  = store_next ? 2'b00 : lo;
          imm = 4 * $urandom_range(0, 63) + lo;
        end
        default: ;
      endcase
    end
    case (op)
      OP_LUI, OP_AUIPC: ins = {imm[31:12], rd, op};
      OP_JAL:           ins = {imm[20], imm[10:1], imm[11], imm[19:12], rd, op};
      OP_STORE:         ins = {imm[11:5], rs2, rs1, f3, imm[4:0], op};
      default:          ins = {imm[11:0], rs1, f3, rd, op};
    endcase
    exp_wen     = (op != OP_STORE);
    exp_load    = (op == OP_LOAD);
    exp_store   = (op == OP_STORE);
    exp_rd      = rd;
    exp_addr    = regs[rs1] + imm;
    exp_next_pc = model_pc + 32'd4;
    lo          = exp_addr[1:0];
    case (op)
      OP_IMM:          exp_wval = exp_addr;
      OP_LUI:          exp_wval = imm;
      OP_AUIPC:        exp_wval = model_pc + imm;
      OP_LOAD:         exp_wval = load_value(mem[exp_addr[9:2]], lo, f3);
      OP_JAL, OP_JALR: exp_wval = model_pc + 32'd4;
      default:         exp_wval = '0;
    endcase
    if (op == OP_JAL) exp_next_pc = model_pc + imm;
    if (op == OP_JALR) exp_next_pc = exp_addr & ~32'd1;
    // store value repeated in every lane it may land in
    exp_mask  = '0;
    exp_wdata = regs[rs2];
    if (f3 == 3'b000) begin
      exp_mask  = byte_mask_t'(4'b0001 << lo);
      exp_wdata = {4{regs[rs2][7:0]}};
    end else if (f3 == 3'b001) begin
      exp_mask  = lo[0] ? 4'b0000 : (lo[1] ? 4'b1100 : 4'b0011);
      exp_wdata = {2{regs[rs2][15:0]}};
    end else if (lo == 2'b00) begin
      exp_mask = 4'b1111;
    end
    // often follow a register write with a sw of that register
    store_next = (n >= 9) && exp_wen && r[16];
    last_rd    = rd;
  endtask

  initial begin
    word_t ins;
    word_t lanes;
    void'($urandom(40));
    model_pc = RESET_PC;
    for (int i = 0; i < 256; i++) begin
      mem[i] = ((DATA_BASE + 4 * i) * 32'h9e37_79b1) ^ 32'hc3a5_5a3c;
    end
    for (int i = 0; i < 32; i++) begin
      regs[i] = '0;
    end
    repeat (10) @(negedge clk);
    rst = 1'b0;
    for (int n = 0; n < NUM_INSTS; n++) begin
      if (pc !== model_pc) report_mismatch("pc", n, model_pc, pc);
      next_insn(n, ins);
      inst = ins;
      #1;
      lanes = {{8{exp_mask[3]}}, {8{exp_mask[2]}}, {8{exp_mask[1]}}, {8{exp_mask[0]}}};
      if (dmem_wen !== exp_store) report_mismatch("store_strobe", n, exp_store, dmem_wen);
      if (dmem_ren !== exp_load) report_mismatch("load_strobe", n, exp_load, dmem_ren);
      if ((exp_load || exp_store) && (dmem_addr !== exp_addr)) begin
        report_mismatch("mem_addr", n, exp_addr, dmem_addr);
      end
      if (dmem_wmask !== (exp_store ? exp_mask : 4'b0000)) begin
        report_mismatch("store_mask", n, exp_store ? exp_mask : 4'b0000, dmem_wmask);
      end
      if (exp_store && ((dmem_wdata & lanes) !== (exp_wdata & lanes))) begin
        report_mismatch("store_data", n, exp_wdata & lanes, dmem_wdata & lanes);
      end
      @(negedge clk);
      // retire what the rising edge just took
      if (exp_wen && (exp_rd != 5'd0)) regs[exp_rd] = exp_wval;
      if (exp_store) begin
        for (int b = 0; b < 4; b++) begin
          if (exp_mask[b]) mem[exp_addr[9:2]][8*b +: 8] = exp_wdata[8*b +: 8];
        end
      end
      model_pc = exp_next_pc;
    end
    if (pc !== model_pc) report_mismatch("pc", NUM_INSTS, model_pc, pc);
    finish_run();
  end

endmodule
